// ==== tracker_settings.svh ====
`ifndef TRACKER_SETTINGS_SVH
`define TRACKER_SETTINGS_SVH

// Active frame size in pixels
`define HRES 1280
`define VRES 720

// Pixel coordinate widths
`define COORD_X_W 11 // Holds 0 to 2047
`define COORD_Y_W 10 // Holds 0 to 1023

// One unpacked color channel
`define CHAN_W 8

// Cycles from a pixel entering the classifier to its mask
// One cycle is the mask register, the rest match the converter
`define CLASSIFY_LATENCY 4

`endif

// ==== tracker_pkg.sv ====
package tracker_pkg;

    // Channel that feeds the threshold compare
    typedef enum logic [2:0] {
        CH_RED   = 3'd0,
        CH_GREEN = 3'd1,
        CH_BLUE  = 3'd2,
        CH_LUMA  = 3'd3,
        CH_CR    = 3'd4,
        CH_CB    = 3'd5
    } channel_e;

    // What is drawn behind the target
    typedef enum logic [1:0] {
        BG_CAMERA  = 2'd0, // Unpacked RGB as received
        BG_CHANNEL = 2'd1, // Selected channel as grey
        BG_LUMA    = 2'd2, // Y as grey
        BG_MASK    = 2'd3  // Black and white mask
    } bg_mode_e;

    typedef enum logic {
        TGT_MASK      = 1'b0, // Masked pixels in pink
        TGT_CROSSHAIR = 1'b1  // Lines through the center of mass
    } target_e;

    // Centroid engine, one shared divider for x then y
    typedef enum logic [1:0] {
        ST_ACCUM = 2'd0,
        ST_DIV_X = 2'd1,
        ST_DIV_Y = 2'd2
    } div_state_e;

endpackage

// ==== ycrcb_convert.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module ycrcb_convert (
    input  logic               clk_pixel,
    input  logic [`CHAN_W-1:0] r_i,
    input  logic [`CHAN_W-1:0] g_i,
    input  logic [`CHAN_W-1:0] b_i,
    output logic [`CHAN_W-1:0] y_o,
    output logic [`CHAN_W-1:0] cr_o,
    output logic [`CHAN_W-1:0] cb_o
);

    // Stage one, coefficient products (each fits in 16 bits)
    logic [15:0] y_r_p, y_g_p, y_b_p;
    logic [15:0] cr_r_p, cr_g_p, cr_b_p;
    logic [15:0] cb_r_p, cb_g_p, cb_b_p;

    // Stage two, weighted sums
    logic [15:0]        y_sum;  // Weights add to 256, so no overflow
    logic signed [17:0] cr_sum;
    logic signed [17:0] cb_sum;

    // Floor divide by 256, recenter on 128 and clamp to a channel
    function automatic logic [`CHAN_W-1:0] offset_clamp(input logic signed [17:0] sum);
        logic signed [10:0] val;
        val = $signed(sum[17:8]) + 11'sd128;
        if (val < 0)
            return '0;
        else if (val > 11'sd255)
            return '1;
        else
            return val[`CHAN_W-1:0];
    endfunction

    always_ff @(posedge clk_pixel) begin
        y_r_p  <= 16'(r_i) * 16'd77;
        y_g_p  <= 16'(g_i) * 16'd150;
        y_b_p  <= 16'(b_i) * 16'd29;
        cr_r_p <= 16'(r_i) * 16'd128;
        cr_g_p <= 16'(g_i) * 16'd107;
        cr_b_p <= 16'(b_i) * 16'd21;
        cb_r_p <= 16'(r_i) * 16'd43;
        cb_g_p <= 16'(g_i) * 16'd85;
        cb_b_p <= 16'(b_i) * 16'd128;
    end

    always_ff @(posedge clk_pixel) begin
        y_sum  <= y_r_p + y_g_p + y_b_p;
        cr_sum <= $signed({2'b00, cr_r_p}) - $signed({2'b00, cr_g_p})
                  - $signed({2'b00, cr_b_p});
        cb_sum <= $signed({2'b00, cb_b_p}) - $signed({2'b00, cb_r_p})
                  - $signed({2'b00, cb_g_p});
    end

    always_ff @(posedge clk_pixel) begin
        y_o  <= y_sum[15:8]; // Always in range
        cr_o <= offset_clamp(cr_sum);
        cb_o <= offset_clamp(cb_sum);
    end

endmodule

// ==== pixel_classifier.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module pixel_classifier import tracker_pkg::*; (
    input  logic                  clk_pixel,
    input  logic                  recent_reset,
    input  logic [15:0]           pixel_i,       // RGB565
    input  logic [`COORD_X_W-1:0] hcount_i,
    input  logic [`COORD_Y_W-1:0] vcount_i,
    input  logic                  active_i,
    input  logic                  frame_end_i,
    input  channel_e              channel_sel_i,
    input  logic [`CHAN_W-1:0]    lower_i,
    input  logic [`CHAN_W-1:0]    upper_i,
    output logic [`CHAN_W-1:0]    red_o,
    output logic [`CHAN_W-1:0]    green_o,
    output logic [`CHAN_W-1:0]    blue_o,
    output logic [`CHAN_W-1:0]    luma_o,
    output logic [`CHAN_W-1:0]    channel_o,
    output logic                  mask_o,
    output logic [`COORD_X_W-1:0] hcount_o,
    output logic [`COORD_Y_W-1:0] vcount_o,
    output logic                  active_o,
    output logic                  frame_end_o
);

    localparam int CONV_DEPTH = `CLASSIFY_LATENCY - 1; // Converter stages

    logic [`CHAN_W-1:0] red_u, green_u, blue_u; // Unpacked, low bits zero
    logic [`CHAN_W-1:0] y_c, cr_c, cb_c;
    logic [`CHAN_W-1:0] chan_sel;

    // Side band delayed to meet the converter output
    logic [`CHAN_W-1:0]    red_d    [CONV_DEPTH];
    logic [`CHAN_W-1:0]    green_d  [CONV_DEPTH];
    logic [`CHAN_W-1:0]    blue_d   [CONV_DEPTH];
    logic [`COORD_X_W-1:0] hcount_d [CONV_DEPTH];
    logic [`COORD_Y_W-1:0] vcount_d [CONV_DEPTH];
    logic                  active_d    [CONV_DEPTH];
    logic                  frame_end_d [CONV_DEPTH];

    assign red_u   = {pixel_i[15:11], 3'b000};
    assign green_u = {pixel_i[10:5], 2'b00};
    assign blue_u  = {pixel_i[4:0], 3'b000};

    ycrcb_convert i_convert (
        .clk_pixel (clk_pixel),
        .r_i       (red_u),
        .g_i       (green_u),
        .b_i       (blue_u),
        .y_o       (y_c),
        .cr_o      (cr_c),
        .cb_o      (cb_c)
    );

    always_ff @(posedge clk_pixel) begin
        red_d[0]    <= red_u;
        green_d[0]  <= green_u;
        blue_d[0]   <= blue_u;
        hcount_d[0] <= hcount_i;
        vcount_d[0] <= vcount_i;
        for (int i = 1; i < CONV_DEPTH; i++) begin
            red_d[i]    <= red_d[i-1];
            green_d[i]  <= green_d[i-1];
            blue_d[i]   <= blue_d[i-1];
            hcount_d[i] <= hcount_d[i-1];
            vcount_d[i] <= vcount_d[i-1];
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            for (int i = 0; i < CONV_DEPTH; i++) begin
                active_d[i]    <= 1'b0;
                frame_end_d[i] <= 1'b0;
            end
        end else begin
            active_d[0]    <= active_i;
            frame_end_d[0] <= frame_end_i;
            for (int i = 1; i < CONV_DEPTH; i++) begin
                active_d[i]    <= active_d[i-1];
                frame_end_d[i] <= frame_end_d[i-1];
            end
        end
    end

    always_comb begin
        case (channel_sel_i)
            CH_RED:   chan_sel = red_d[CONV_DEPTH-1];
            CH_GREEN: chan_sel = green_d[CONV_DEPTH-1];
            CH_BLUE:  chan_sel = blue_d[CONV_DEPTH-1];
            CH_CR:    chan_sel = cr_c;
            CH_CB:    chan_sel = cb_c;
            default:  chan_sel = y_c; // Luma, also for unused codes
        endcase
    end

    // Final stage, everything leaves together with the mask
    always_ff @(posedge clk_pixel) begin
        red_o     <= red_d[CONV_DEPTH-1];
        green_o   <= green_d[CONV_DEPTH-1];
        blue_o    <= blue_d[CONV_DEPTH-1];
        luma_o    <= y_c;
        channel_o <= chan_sel;
        hcount_o  <= hcount_d[CONV_DEPTH-1];
        vcount_o  <= vcount_d[CONV_DEPTH-1];
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            mask_o      <= 1'b0;
            active_o    <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            mask_o      <= active_d[CONV_DEPTH-1] && (chan_sel >= lower_i)
                           && (chan_sel <= upper_i);
            active_o    <= active_d[CONV_DEPTH-1];
            frame_end_o <= frame_end_d[CONV_DEPTH-1];
        end
    end

endmodule

// ==== centroid_tracker.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module centroid_tracker import tracker_pkg::*; (
    input  logic                  clk_pixel,
    input  logic                  recent_reset,
    input  logic                  mask_i,
    input  logic [`COORD_X_W-1:0] hcount_i,
    input  logic [`COORD_Y_W-1:0] vcount_i,
    input  logic                  frame_end_i,
    output logic [`COORD_X_W-1:0] com_x_o,
    output logic [`COORD_Y_W-1:0] com_y_o,
    output logic                  com_valid_o
);

    localparam int COUNT_W   = $clog2(`HRES * `VRES + 1); // A full frame of mask
    localparam int SUM_X_W   = `COORD_X_W + COUNT_W;
    localparam int SUM_Y_W   = `COORD_Y_W + COUNT_W;
    localparam int BIT_CNT_W = $clog2(SUM_X_W + 1);

    div_state_e state;

    logic [SUM_X_W-1:0] sum_x;
    logic [SUM_Y_W-1:0] sum_y;
    logic [COUNT_W-1:0] count;

    // Divider, the dividend register fills with quotient bits from the bottom
    logic [SUM_Y_W-1:0]    sum_y_hold; // Waits while x is divided
    logic [COUNT_W-1:0]    div_count;
    logic [SUM_X_W-1:0]    div_dvd;
    logic [COUNT_W-1:0]    div_rem;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [`COORD_X_W-1:0] x_result;

    logic [COUNT_W:0]   rem_shift;
    logic [COUNT_W:0]   rem_next;
    logic               q_bit;
    logic [SUM_X_W-1:0] dvd_next;

    // One restoring step
    always_comb begin
        rem_shift = {div_rem, div_dvd[SUM_X_W-1]};
        if (rem_shift >= {1'b0, div_count}) begin
            rem_next = rem_shift - {1'b0, div_count};
            q_bit    = 1'b1;
        end else begin
            rem_next = rem_shift;
            q_bit    = 1'b0;
        end
        dvd_next = {div_dvd[SUM_X_W-2:0], q_bit};
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state       <= ST_ACCUM;
            sum_x       <= '0;
            sum_y       <= '0;
            count       <= '0;
            bit_cnt     <= '0;
            com_x_o     <= '0;
            com_y_o     <= '0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= 1'b0;
            case (state)
                ST_ACCUM: begin
                    if (frame_end_i) begin
                        if (count != '0) begin
                            sum_y_hold <= sum_y;
                            div_count  <= count;
                            div_dvd    <= sum_x;
                            div_rem    <= '0;
                            bit_cnt    <= BIT_CNT_W'(SUM_X_W);
                            state      <= ST_DIV_X;
                        end
                        sum_x <= '0; // Next frame starts clean
                        sum_y <= '0;
                        count <= '0;
                    end else if (mask_i) begin
                        sum_x <= sum_x + SUM_X_W'(hcount_i);
                        sum_y <= sum_y + SUM_Y_W'(vcount_i);
                        count <= count + 1'b1;
                    end
                end
                ST_DIV_X: begin
                    if (bit_cnt == BIT_CNT_W'(1)) begin
                        x_result <= dvd_next[`COORD_X_W-1:0];
                        div_dvd  <= {sum_y_hold, {(SUM_X_W - SUM_Y_W){1'b0}}}; // Left aligned
                        div_rem  <= '0;
                        bit_cnt  <= BIT_CNT_W'(SUM_Y_W);
                        state    <= ST_DIV_Y;
                    end else begin
                        div_dvd <= dvd_next;
                        div_rem <= rem_next[COUNT_W-1:0];
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ST_DIV_Y: begin
                    if (bit_cnt == BIT_CNT_W'(1)) begin
                        com_x_o     <= x_result;
                        com_y_o     <= dvd_next[`COORD_Y_W-1:0];
                        com_valid_o <= 1'b1;
                        state       <= ST_ACCUM;
                    end else begin
                        div_dvd <= dvd_next;
                        div_rem <= rem_next[COUNT_W-1:0];
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: state <= ST_ACCUM;
            endcase
        end
    end

endmodule

// ==== video_overlay.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module video_overlay import tracker_pkg::*; (
    input  logic                  clk_pixel,
    input  logic                  recent_reset,
    input  bg_mode_e              bg_sel_i,
    input  target_e               target_sel_i,
    input  logic [`CHAN_W-1:0]    red_i,
    input  logic [`CHAN_W-1:0]    green_i,
    input  logic [`CHAN_W-1:0]    blue_i,
    input  logic [`CHAN_W-1:0]    luma_i,
    input  logic [`CHAN_W-1:0]    channel_i,
    input  logic                  mask_i,
    input  logic [`COORD_X_W-1:0] hcount_i,
    input  logic [`COORD_Y_W-1:0] vcount_i,
    input  logic                  active_i,
    input  logic [`COORD_X_W-1:0] com_x_i,
    input  logic [`COORD_Y_W-1:0] com_y_i,
    output logic [`CHAN_W-1:0]    red_o,
    output logic [`CHAN_W-1:0]    green_o,
    output logic [`CHAN_W-1:0]    blue_o,
    output logic [`COORD_X_W-1:0] hcount_o,
    output logic [`COORD_Y_W-1:0] vcount_o,
    output logic                  active_o
);

    logic [3*`CHAN_W-1:0] bg_rgb;
    logic [3*`CHAN_W-1:0] pix_rgb;
    logic                 in_frame;
    logic                 on_cross;

    assign in_frame = active_i && (hcount_i < `COORD_X_W'(`HRES))
                      && (vcount_i < `COORD_Y_W'(`VRES));
    assign on_cross = (hcount_i == com_x_i) || (vcount_i == com_y_i);

    always_comb begin
        case (bg_sel_i)
            BG_CAMERA:  bg_rgb = {red_i, green_i, blue_i};
            BG_CHANNEL: bg_rgb = {3{channel_i}};
            BG_LUMA:    bg_rgb = {3{luma_i}};
            default:    bg_rgb = mask_i ? '1 : '0; // Mask view
        endcase

        pix_rgb = bg_rgb;
        if (target_sel_i == TGT_MASK && mask_i)
            pix_rgb = {8'hFF, 8'h77, 8'hAA}; // Pink
        else if (target_sel_i == TGT_CROSSHAIR && on_cross)
            pix_rgb = '1;
        if (!in_frame)
            pix_rgb = '0; // Blanking
    end

    always_ff @(posedge clk_pixel) begin
        hcount_o <= hcount_i;
        vcount_o <= vcount_i;
        if (recent_reset) begin
            {red_o, green_o, blue_o} <= '0;
            active_o                 <= 1'b0;
        end else begin
            {red_o, green_o, blue_o} <= pix_rgb;
            active_o                 <= active_i;
        end
    end

endmodule

// ==== color_tracker_top.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module color_tracker_top import tracker_pkg::*; (
    input  logic                  clk_pixel,
    input  logic                  recent_reset,
    input  logic [15:0]           pixel_i,
    input  logic [`COORD_X_W-1:0] hcount_i,
    input  logic [`COORD_Y_W-1:0] vcount_i,
    input  logic                  active_i,
    input  logic                  frame_end_i,
    input  channel_e              channel_sel_i,
    input  logic [`CHAN_W-1:0]    lower_i,
    input  logic [`CHAN_W-1:0]    upper_i,
    input  bg_mode_e              bg_sel_i,
    input  target_e               target_sel_i,
    output logic [`CHAN_W-1:0]    red_o,
    output logic [`CHAN_W-1:0]    green_o,
    output logic [`CHAN_W-1:0]    blue_o,
    output logic [`COORD_X_W-1:0] hcount_o,
    output logic [`COORD_Y_W-1:0] vcount_o,
    output logic                  active_o,
    output logic [`COORD_X_W-1:0] com_x_o,
    output logic [`COORD_Y_W-1:0] com_y_o,
    output logic                  com_valid_o
);

    // Classifier results, CLASSIFY_LATENCY behind the inputs
    logic [`CHAN_W-1:0]    cls_red, cls_green, cls_blue;
    logic [`CHAN_W-1:0]    cls_luma, cls_channel;
    logic                  cls_mask;
    logic [`COORD_X_W-1:0] cls_hcount;
    logic [`COORD_Y_W-1:0] cls_vcount;
    logic                  cls_active;
    logic                  cls_frame_end;

    pixel_classifier i_classifier (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel_i       (pixel_i),
        .hcount_i      (hcount_i),
        .vcount_i      (vcount_i),
        .active_i      (active_i),
        .frame_end_i   (frame_end_i),
        .channel_sel_i (channel_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .red_o         (cls_red),
        .green_o       (cls_green),
        .blue_o        (cls_blue),
        .luma_o        (cls_luma),
        .channel_o     (cls_channel),
        .mask_o        (cls_mask),
        .hcount_o      (cls_hcount),
        .vcount_o      (cls_vcount),
        .active_o      (cls_active),
        .frame_end_o   (cls_frame_end)
    );

    centroid_tracker i_tracker (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .mask_i       (cls_mask),
        .hcount_i     (cls_hcount),
        .vcount_i     (cls_vcount),
        .frame_end_i  (cls_frame_end),
        .com_x_o      (com_x_o),
        .com_y_o      (com_y_o),
        .com_valid_o  (com_valid_o)
    );

    video_overlay i_overlay (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .bg_sel_i     (bg_sel_i),
        .target_sel_i (target_sel_i),
        .red_i        (cls_red),
        .green_i      (cls_green),
        .blue_i       (cls_blue),
        .luma_i       (cls_luma),
        .channel_i    (cls_channel),
        .mask_i       (cls_mask),
        .hcount_i     (cls_hcount),
        .vcount_i     (cls_vcount),
        .active_i     (cls_active),
        .com_x_i      (com_x_o),   // Last valid centroid
        .com_y_i      (com_y_o),
        .red_o        (red_o),
        .green_o      (green_o),
        .blue_o       (blue_o),
        .hcount_o     (hcount_o),
        .vcount_o     (vcount_o),
        .active_o     (active_o)
    );

endmodule

// ==== tb_color_tracker.sv ====
`timescale 1ns/1ns
`include "tracker_settings.svh"

module tb_color_tracker import tracker_pkg::*; ();

    localparam int WIN_W       = 64;
    localparam int WIN_H       = 48;
    localparam int FIELDS      = 14;  // Hex words per pattern line
    localparam int MAX_TESTS   = 32;
    localparam int COM_TIMEOUT = 200;
    localparam int PIPE_DELAY  = 5;   // Pixel in to color out
    localparam logic [15:0] NOISE_BITS = 16'h0821; // Lowest bit of each color field

    logic                  clk_pixel;
    logic                  recent_reset;
    logic [15:0]           pixel_i;
    logic [`COORD_X_W-1:0] hcount_i;
    logic [`COORD_Y_W-1:0] vcount_i;
    logic                  active_i;
    logic                  frame_end_i;
    channel_e              channel_sel_i;
    logic [`CHAN_W-1:0]    lower_i;
    logic [`CHAN_W-1:0]    upper_i;
    bg_mode_e              bg_sel_i;
    target_e               target_sel_i;
    logic [`CHAN_W-1:0]    red_o, green_o, blue_o;
    logic [`COORD_X_W-1:0] hcount_o;
    logic [`COORD_Y_W-1:0] vcount_o;
    logic                  active_o;
    logic [`COORD_X_W-1:0] com_x_o;
    logic [`COORD_Y_W-1:0] com_y_o;
    logic                  com_valid_o;

    logic [31:0] pat [MAX_TESTS*FIELDS];

    // Expected output stream with the oldest first
    logic [23:0]           exp_rgb_q [$];
    logic [`COORD_X_W-1:0] exp_h_q   [$];
    logic [`COORD_Y_W-1:0] exp_v_q   [$];
    int                    exp_cyc_q [$];

    int                    cycle = 0;
    int                    test_errors;
    int                    tests_passed;
    int                    tests_failed;
    integer                seed;
    string                 test_name;
    logic [`COORD_X_W-1:0] held_x; // Centroid the overlay is drawing
    logic [`COORD_Y_W-1:0] held_y;

    color_tracker_top i_dut (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel_i       (pixel_i),
        .hcount_i      (hcount_i),
        .vcount_i      (vcount_i),
        .active_i      (active_i),
        .frame_end_i   (frame_end_i),
        .channel_sel_i (channel_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .bg_sel_i      (bg_sel_i),
        .target_sel_i  (target_sel_i),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hcount_o      (hcount_o),
        .vcount_o      (vcount_o),
        .active_o      (active_o),
        .com_x_o       (com_x_o),
        .com_y_o       (com_y_o),
        .com_valid_o   (com_valid_o)
    );

    always #4 clk_pixel = ~clk_pixel;

    always @(posedge clk_pixel) cycle <= cycle + 1;

    function automatic int clamp_byte(input int v);
        if (v < 0)
            return 0;
        if (v > 255)
            return 255;
        return v;
    endfunction

    // Unpack RGB565 and convert with floor division by arithmetic shift
    function automatic int channel_value(input logic [15:0] pix, input channel_e chan);
        int r, g, b, y, cr, cb;
        r  = int'({pix[15:11], 3'b000});
        g  = int'({pix[10:5], 2'b00});
        b  = int'({pix[4:0], 3'b000});
        y  = (77 * r + 150 * g + 29 * b) >>> 8;
        cr = clamp_byte(128 + ((128 * r - 107 * g - 21 * b) >>> 8));
        cb = clamp_byte(128 + ((128 * b - 43 * r - 85 * g) >>> 8));
        case (chan)
            CH_RED:   return r;
            CH_GREEN: return g;
            CH_BLUE:  return b;
            CH_LUMA:  return y;
            CH_CR:    return cr;
            CH_CB:    return cb;
            default:  return 0;
        endcase
    endfunction

    function automatic logic [23:0] overlay_rgb(input logic [15:0] pix, input int chan_val,
                                                input logic mask, input int x, input int y,
                                                input bg_mode_e bg, input target_e tgt);
        logic [23:0] rgb;
        logic [7:0]  grey;
        case (bg)
            BG_CAMERA:  rgb = {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000};
            BG_CHANNEL: begin
                grey = 8'(chan_val);
                rgb  = {grey, grey, grey};
            end
            BG_LUMA: begin
                grey = 8'(channel_value(pix, CH_LUMA));
                rgb  = {grey, grey, grey};
            end
            default:    rgb = mask ? 24'hFFFFFF : 24'h000000;
        endcase
        if (tgt == TGT_MASK && mask)
            rgb = 24'hFF77AA;
        else if (tgt == TGT_CROSSHAIR && (x == int'(held_x) || y == int'(held_y)))
            rgb = 24'hFFFFFF;
        return rgb;
    endfunction

    // Sweep the window once and queue the predicted output of each pixel
    task automatic run_frame(input int base, output int mask_count);
        logic [15:0] pix;
        int          val;
        logic        mask;
        int          x0, y0, x1, y1;
        x0 = int'(pat[base+6]);
        y0 = int'(pat[base+7]);
        x1 = x0 + int'(pat[base+8]);
        y1 = y0 + int'(pat[base+9]);
        mask_count = 0;
        for (int y = 0; y < WIN_H; y++) begin
            for (int x = 0; x < WIN_W; x++) begin
                if (x >= x0 && x < x1 && y >= y0 && y < y1)
                    pix = pat[base+10][15:0];
                else
                    pix = pat[base+11][15:0] ^ (16'($random(seed)) & NOISE_BITS);
                val  = channel_value(pix, channel_e'(pat[base+1][2:0]));
                mask = val >= int'(pat[base+2]) && val <= int'(pat[base+3]);
                if (mask)
                    mask_count++;
                @(posedge clk_pixel);
                pixel_i  <= pix;
                hcount_i <= `COORD_X_W'(x);
                vcount_i <= `COORD_Y_W'(y);
                active_i <= 1'b1;
                exp_rgb_q.push_back(overlay_rgb(pix, val, mask, x, y,
                                                bg_mode_e'(pat[base+4][1:0]),
                                                target_e'(pat[base+5][0])));
                exp_h_q.push_back(`COORD_X_W'(x));
                exp_v_q.push_back(`COORD_Y_W'(y));
                exp_cyc_q.push_back(cycle + 1); // Cycle at which the DUT sees it
            end
        end
        @(posedge clk_pixel);
        active_i    <= 1'b0;
        frame_end_i <= 1'b1;
        @(posedge clk_pixel);
        frame_end_i <= 1'b0;
    endtask

    task automatic check_centroid(input int base, input int mask_count);
        logic [`COORD_X_W-1:0] want_x;
        logic [`COORD_Y_W-1:0] want_y;
        bit                    got;
        int                    n;
        want_x = `COORD_X_W'(pat[base+12]);
        want_y = `COORD_Y_W'(pat[base+13]);
        got    = 1'b0;
        n      = 0;
        while (!got && n < COM_TIMEOUT) begin
            @(negedge clk_pixel);
            got = com_valid_o;
            n++;
        end
        if (mask_count > 0) begin
            assert (got) else begin
                $display("%s: the centroid never arrived within %0d cycles", test_name,
                         COM_TIMEOUT);
                test_errors++;
            end
            if (got) begin
                @(negedge clk_pixel);
                assert (!com_valid_o) else begin
                    $display("%s: com_valid_o stayed high for more than one cycle", test_name);
                    test_errors++;
                end
            end
        end else begin
            assert (!got) else begin
                $display("%s: a centroid was reported for a frame with an empty mask",
                         test_name);
                test_errors++;
            end
        end
        assert (com_x_o == want_x) else begin
            $display("ERROR %s: com_x expected %0d actual %0d", test_name, want_x, com_x_o);
            test_errors++;
        end
        assert (com_y_o == want_y) else begin
            $display("ERROR %s: com_y expected %0d actual %0d", test_name, want_y, com_y_o);
            test_errors++;
        end
        held_x = want_x;
        held_y = want_y;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rgb_q.size() > 0 && n < 4 * PIPE_DELAY) begin
            @(negedge clk_pixel);
            n++;
        end
        assert (exp_rgb_q.size() == 0) else begin
            $display("%s: %0d expected output pixels never came out", test_name,
                     exp_rgb_q.size());
            test_errors++;
            exp_rgb_q.delete();
            exp_h_q.delete();
            exp_v_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // Every active output pixel against the model
    always @(negedge clk_pixel) begin : check_output
        logic [23:0]           want_rgb;
        logic [`COORD_X_W-1:0] want_h;
        logic [`COORD_Y_W-1:0] want_v;
        int                    want_cyc;
        if (active_o) begin
            assert (exp_rgb_q.size() > 0) else begin
                $display("%s: an active output pixel came out with no pixel pending",
                         test_name);
                test_errors++;
            end
            if (exp_rgb_q.size() > 0) begin
                want_rgb = exp_rgb_q.pop_front();
                want_h   = exp_h_q.pop_front();
                want_v   = exp_v_q.pop_front();
                want_cyc = exp_cyc_q.pop_front();
                assert ({red_o, green_o, blue_o} == want_rgb) else begin
                    $display("ERROR %s: rgb at (%0d,%0d) expected %06h actual %06h", test_name,
                             want_h, want_v, want_rgb, {red_o, green_o, blue_o});
                    test_errors++;
                end
                assert (hcount_o == want_h && vcount_o == want_v) else begin
                    $display("ERROR %s: position expected (%0d,%0d) actual (%0d,%0d)",
                             test_name, want_h, want_v, hcount_o, vcount_o);
                    test_errors++;
                end
                assert (cycle == want_cyc + PIPE_DELAY) else begin
                    $display("ERROR %s: latency expected %0d actual %0d", test_name,
                             PIPE_DELAY, cycle - want_cyc);
                    test_errors++;
                end
            end
        end
    end

    initial begin
        int base;
        int mask_count;
        clk_pixel     = 1'b0;
        recent_reset  = 1'b1;
        pixel_i       = '0;
        hcount_i      = '0;
        vcount_i      = '0;
        active_i      = 1'b0;
        frame_end_i   = 1'b0;
        channel_sel_i = CH_RED;
        lower_i       = '0;
        upper_i       = '0;
        bg_sel_i      = BG_CAMERA;
        target_sel_i  = TGT_MASK;
        seed          = 32'h433b3bca;
        test_errors   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        held_x        = '0;
        held_y        = '0;
        test_name     = "reset";
        for (int i = 0; i < MAX_TESTS * FIELDS; i++)
            pat[i] = '1; // End marker for unused lines
        $readmemh("color_tracker_patterns.txt", pat);

        repeat (10) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        @(negedge clk_pixel);
        assert (!active_o && !com_valid_o && com_x_o == '0 && com_y_o == '0
                && {red_o, green_o, blue_o} == '0) else begin
            $display("ERROR %s: outputs expected 0 actual %0b %0b (%0d,%0d) %06h",
                     test_name, active_o, com_valid_o, com_x_o, com_y_o,
                     {red_o, green_o, blue_o});
            test_errors++;
        end
        report_test();

        for (int t = 0; t < MAX_TESTS && pat[t*FIELDS] != 32'hFFFF_FFFF; t++) begin
            base      = t * FIELDS;
            test_name = $sformatf("test_%0d", pat[base]);
            @(posedge clk_pixel);
            channel_sel_i <= channel_e'(pat[base+1][2:0]);
            lower_i       <= pat[base+2][7:0];
            upper_i       <= pat[base+3][7:0];
            bg_sel_i      <= bg_mode_e'(pat[base+4][1:0]);
            target_sel_i  <= target_e'(pat[base+5][0]);
            @(posedge clk_pixel);
            run_frame(base, mask_count);
            check_centroid(base, mask_count);
            wait_drain();
            report_test();
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== color_tracker_patterns.txt ====
// idx chan lower upper bg tgt x0 y0 w h rect_rgb565 bg_rgb565 com_x com_y, all hex
// chan 0 red 1 green 2 blue 3 luma 4 cr 5 cb, bg 0 camera 1 channel 2 luma 3 mask, tgt 0 mask 1 crosshair
01 0 C0 FF 3 1 0A 08 14 0C F800 2104 13 0D
02 1 E0 FF 0 0 1E 14 10 10 07E0 2104 25 1B
03 3 F0 FF 1 1 00 00 08 08 FFFF 2104 03 03
04 4 F0 FF 1 1 28 1E 18 12 F800 2104 33 26
05 5 F0 FF 1 1 05 19 0A 14 001F 2104 09 22
06 3 F0 FF 2 0 32 02 0D 07 FFFF 2104 38 05
07 0 50 60 0 1 0A 0A 04 04 F800 2104 38 05
08 2 80 FF 0 1 14 28 1E 05 001F 2104 22 2A
09 1 E0 FF 3 0 01 01 01 01 07E0 2104 01 01
0A 0 00 FF 3 1 00 00 01 01 F800 2104 1F 17
0B 5 FF 00 2 1 00 00 01 01 001F 2104 1F 17
0C 1 FC FC 1 0 3C 2C 04 04 07E0 2104 3D 2D
0D 0 F8 F8 3 1 02 28 06 08 F81F 2104 04 2B
0E 3 FB FF 0 0 08 08 08 08 FFFF 2104 04 2B

// ==== project.f ====
+incdir+.
tracker_pkg.sv
ycrcb_convert.sv
pixel_classifier.sv
centroid_tracker.sv
video_overlay.sv
color_tracker_top.sv
tb_color_tracker.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/1ns -Wno-fatal
TOP      = tb_color_tracker
FILELIST = project.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
